//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --assert --timing --timescale 1ns/10ps -j 0
TOP ?= ucodeCoreTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/flowQueue.sv
`timescale 1ns/10ps
`default_nettype none

// Circular buffer of pending flow entries
module flowQueue #(
	parameter type payloadT = logic [7:0],
	parameter int depth = 4
) (
	input logic clock,
	input logic rstN,
	input logic push,
	input payloadT pushData,
	input logic pop,
	output payloadT head,
	output logic notEmpty,
	output logic full
);

	payloadT mem [depth];
	logic [$clog2(depth)-1:0] rdPtr;
	logic [$clog2(depth)-1:0] wrPtr;
	// One extra bit so depth itself fits
	logic [$clog2(depth):0] count;

	// Wrap at depth, not only at a power of two
	function automatic logic [$clog2(depth)-1:0] nextPtr(input logic [$clog2(depth)-1:0] ptr);
		return (ptr == ($clog2(depth))'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	assign head = mem[rdPtr];
	assign notEmpty = count != '0;
	// Counts the push already in flight, so a strobe seen with full low
	// always finds a free slot one cycle later
	assign full = count == ($clog2(depth)+1)'(depth) ||
		(count == ($clog2(depth)+1)'(depth - 1) && push);

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Source kept off while full
	noPushWhenFull: assert property (@(posedge clock) disable iff (!rstN)
		push |-> count != ($clog2(depth)+1)'(depth));

	// Sequencer only pops a present entry
	noPopWhenEmpty: assert property (@(posedge clock) disable iff (!rstN)
		pop |-> notEmpty);

endmodule

`default_nettype wire

//--- design/prefixDecoder.sv
`timescale 1ns/10ps
`default_nettype none

// Opcode byte to flow index, with CB prefix merge
module prefixDecoder (
	input logic clock,
	input logic rstN,
	input logic opStrobe,
	input logic [ucodePkg::opcodeWidth-1:0] opByte,
	output logic push,
	output ucodePkg::flowEntryT entry
);

	// Last strobed byte was the CB prefix
	logic cbPending;
	logic [ucodePkg::flowIdxWidth-1:0] mainIdx;
	logic [ucodePkg::flowIdxWidth-1:0] cbIdx;

	//////////////////////////////////////////////////////////////////////
	// Lookup tables
	//////////////////////////////////////////////////////////////////////

	// Main table
	always_comb
	begin
		case (opByte)
			ucodePkg::opNop:    mainIdx = ucodePkg::flowDefault;
			ucodePkg::opLdBn:   mainIdx = ucodePkg::flowLdBn;
			ucodePkg::opLdCn:   mainIdx = ucodePkg::flowLdCn;
			ucodePkg::opIncB:   mainIdx = ucodePkg::flowIncB;
			ucodePkg::opDecB:   mainIdx = ucodePkg::flowDecB;
			ucodePkg::opJrn:    mainIdx = ucodePkg::flowJrn;
			ucodePkg::opLdHLnn: mainIdx = ucodePkg::flowLdHLnn;
			ucodePkg::opIncHL:  mainIdx = ucodePkg::flowIncHL;
			ucodePkg::opDi:     mainIdx = ucodePkg::flowDi;
			ucodePkg::opCpn:    mainIdx = ucodePkg::flowCpn;
			default:            mainIdx = ucodePkg::flowDefault;
		endcase
	end

	// CB table, unknown codes fall back to the default flow
	always_comb
	begin
		case (opByte)
			ucodePkg::cbBit7H: cbIdx = ucodePkg::flowCbBit7H;
			ucodePkg::cbRlC:   cbIdx = ucodePkg::flowCbRlC;
			default:           cbIdx = ucodePkg::flowDefault;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Registered push
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			cbPending <= 1'b0;
			push <= 1'b0;
		end
		else
		begin
			// Prefix byte alone pushes nothing
			push <= opStrobe && (cbPending || opByte != ucodePkg::opPrefixCb);
			if (opStrobe)
				cbPending <= !cbPending && opByte == ucodePkg::opPrefixCb;
		end
	end

	// Payload, qualified by push
	always_ff @(posedge clock)
	begin
		if (opStrobe)
		begin
			entry.flowIdx <= cbPending ? cbIdx : mainIdx;
			entry.opcode <= opByte;
		end
	end

endmodule

`default_nettype wire

//--- design/ucodeCore.sv
`timescale 1ns/10ps
`default_nettype none

// Decoder, flow queue and sequencer
module ucodeCore (
	input logic clock,
	input logic rstN,
	input logic opStrobe,
	input logic [ucodePkg::opcodeWidth-1:0] opByte,
	output logic full,
	output logic uopValid,
	output ucodePkg::uopT uop,
	output logic flowDone,
	output logic [ucodePkg::pcWidth-1:0] pc
);

	logic push;
	logic pop;
	logic notEmpty;
	ucodePkg::flowEntryT pushEntry;
	ucodePkg::flowEntryT headEntry;

	prefixDecoder i_prefixDecoder (
		.clock(clock),
		.rstN(rstN),
		.opStrobe(opStrobe),
		.opByte(opByte),
		.push(push),
		.entry(pushEntry)
	);

	flowQueue #(
		.payloadT(ucodePkg::flowEntryT),
		.depth(ucodePkg::queueDepth)
	) i_flowQueue (
		.clock(clock),
		.rstN(rstN),
		.push(push),
		.pushData(pushEntry),
		.pop(pop),
		.head(headEntry),
		.notEmpty(notEmpty),
		.full(full)
	);

	ucodeSequencer i_ucodeSequencer (
		.clock(clock),
		.rstN(rstN),
		.notEmpty(notEmpty),
		.head(headEntry),
		.pop(pop),
		.uopValid(uopValid),
		.uop(uop),
		.flowDone(flowDone),
		.pc(pc)
	);

endmodule

`default_nettype wire

//--- design/ucodeFlows.svh
`ifndef UCODE_FLOWS_SVH
`define UCODE_FLOWS_SVH

//////////////////////////////////////////////////////////////////////
// Micro-op ROM
//////////////////////////////////////////////////////////////////////

// Flows run from their entry point until an end-of-flow word
// Count of inc words per flow equals the instruction length in bytes
function automatic ucodePkg::uopT romRead(input logic [ucodePkg::flowIdxWidth-1:0] addr);
	ucodePkg::uopT word;
	case (addr)
		// Default, single byte
		ucodePkg::flowDefault:
			word = '{ucodePkg::nextIncEof, ucodePkg::uopNop, ucodePkg::regNull};
		// LD B,n
		ucodePkg::flowLdBn:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowLdBn + 8'd1:
			word = '{ucodePkg::nextInc, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowLdBn + 8'd2:
			word = '{ucodePkg::nextEof, ucodePkg::uopSrm, ucodePkg::regB};
		// LD C,n
		ucodePkg::flowLdCn:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowLdCn + 8'd1:
			word = '{ucodePkg::nextInc, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowLdCn + 8'd2:
			word = '{ucodePkg::nextEof, ucodePkg::uopSrm, ucodePkg::regC};
		// INC B and DEC B
		ucodePkg::flowIncB:
			word = '{ucodePkg::nextIncEof, ucodePkg::uopInc16, ucodePkg::regB};
		ucodePkg::flowDecB:
			word = '{ucodePkg::nextIncEofFu, ucodePkg::uopDec16, ucodePkg::regB};
		// JR n
		ucodePkg::flowJrn:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowJrn + 8'd1:
			word = '{ucodePkg::nextOp, ucodePkg::uopNop, ucodePkg::regNull};
		// Offset byte into x8
		ucodePkg::flowJrn + 8'd2:
			word = '{ucodePkg::nextInc, ucodePkg::uopSrm, ucodePkg::regX8};
		ucodePkg::flowJrn + 8'd3:
			word = '{ucodePkg::nextOp, ucodePkg::uopSx16r, ucodePkg::regPc};
		// x16 = pc + sign extended x8
		ucodePkg::flowJrn + 8'd4:
			word = '{ucodePkg::nextOp, ucodePkg::uopAddx16, ucodePkg::regX8};
		ucodePkg::flowJrn + 8'd5:
			word = '{ucodePkg::nextEof, ucodePkg::uopSpc, ucodePkg::regX16};
		// LD HL,nn, low byte first
		ucodePkg::flowLdHLnn:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowLdHLnn + 8'd1:
			word = '{ucodePkg::nextInc, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowLdHLnn + 8'd2:
			word = '{ucodePkg::nextOp, ucodePkg::uopSrm, ucodePkg::regL};
		ucodePkg::flowLdHLnn + 8'd3:
			word = '{ucodePkg::nextIncEof, ucodePkg::uopSrm, ucodePkg::regH};
		// INC HL and DI
		ucodePkg::flowIncHL:
			word = '{ucodePkg::nextIncEof, ucodePkg::uopInc16, ucodePkg::regHl};
		ucodePkg::flowDi:
			word = '{ucodePkg::nextIncEof, ucodePkg::uopCeti, ucodePkg::regNull};
		// CP n, compare as a - literal
		ucodePkg::flowCpn:
			word = '{ucodePkg::nextInc, ucodePkg::uopSx16r, ucodePkg::regA};
		ucodePkg::flowCpn + 8'd1:
			word = '{ucodePkg::nextOp, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowCpn + 8'd2:
			word = '{ucodePkg::nextOp, ucodePkg::uopSrm, ucodePkg::regX8};
		ucodePkg::flowCpn + 8'd3:
			word = '{ucodePkg::nextIncEofFu, ucodePkg::uopSubx16, ucodePkg::regX8};
		// CB BIT 7,H
		ucodePkg::flowCbBit7H:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowCbBit7H + 8'd1:
			word = '{ucodePkg::nextOp, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowCbBit7H + 8'd2:
			word = '{ucodePkg::nextInc, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowCbBit7H + 8'd3:
			word = '{ucodePkg::nextEofFu, ucodePkg::uopBit, ucodePkg::regH};
		// CB RL C
		ucodePkg::flowCbRlC:
			word = '{ucodePkg::nextInc, ucodePkg::uopSma, ucodePkg::regPc};
		ucodePkg::flowCbRlC + 8'd1:
			word = '{ucodePkg::nextOp, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowCbRlC + 8'd2:
			word = '{ucodePkg::nextInc, ucodePkg::uopNop, ucodePkg::regNull};
		ucodePkg::flowCbRlC + 8'd3:
			word = '{ucodePkg::nextEofFu, ucodePkg::uopShl, ucodePkg::regC};
		// Unused words
		default:
			word = '{ucodePkg::nextOp, ucodePkg::uopNop, ucodePkg::regNull};
	endcase
	return word;
endfunction

`endif

//--- design/ucodePkg.sv
`default_nettype none

package ucodePkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	localparam int opcodeWidth = 8;
	localparam int flowIdxWidth = 8;
	localparam int pcWidth = 16;
	// Pending flow entries between decoder and sequencer
	localparam int queueDepth = 4;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam logic [opcodeWidth-1:0] opNop = 8'h00;
	localparam logic [opcodeWidth-1:0] opIncB = 8'h04;
	localparam logic [opcodeWidth-1:0] opDecB = 8'h05;
	localparam logic [opcodeWidth-1:0] opLdBn = 8'h06;
	localparam logic [opcodeWidth-1:0] opLdCn = 8'h0E;
	localparam logic [opcodeWidth-1:0] opJrn = 8'h18;
	localparam logic [opcodeWidth-1:0] opLdHLnn = 8'h21;
	localparam logic [opcodeWidth-1:0] opIncHL = 8'h23;
	localparam logic [opcodeWidth-1:0] opPrefixCb = 8'hCB;
	localparam logic [opcodeWidth-1:0] opDi = 8'hF3;
	localparam logic [opcodeWidth-1:0] opCpn = 8'hFE;
	// Second byte after the CB prefix
	localparam logic [opcodeWidth-1:0] cbBit7H = 8'h7C;
	localparam logic [opcodeWidth-1:0] cbRlC = 8'h11;

	//////////////////////////////////////////////////////////////////////
	// Flow entry points in the micro-op ROM
	//////////////////////////////////////////////////////////////////////

	// Also the one-word flow of every unknown opcode
	localparam logic [flowIdxWidth-1:0] flowDefault = 8'd0;
	localparam logic [flowIdxWidth-1:0] flowLdBn = 8'd1;
	localparam logic [flowIdxWidth-1:0] flowLdCn = 8'd4;
	localparam logic [flowIdxWidth-1:0] flowIncB = 8'd7;
	localparam logic [flowIdxWidth-1:0] flowDecB = 8'd8;
	localparam logic [flowIdxWidth-1:0] flowJrn = 8'd9;
	localparam logic [flowIdxWidth-1:0] flowLdHLnn = 8'd15;
	localparam logic [flowIdxWidth-1:0] flowIncHL = 8'd19;
	localparam logic [flowIdxWidth-1:0] flowDi = 8'd20;
	localparam logic [flowIdxWidth-1:0] flowCpn = 8'd21;
	// CB flows carry their own copy of the prefix step
	localparam logic [flowIdxWidth-1:0] flowCbBit7H = 8'd25;
	localparam logic [flowIdxWidth-1:0] flowCbRlC = 8'd29;
	// Last populated ROM word
	localparam logic [flowIdxWidth-1:0] romLastAddr = 8'd32;

	//////////////////////////////////////////////////////////////////////
	// Micro-op fields
	//////////////////////////////////////////////////////////////////////

	// Next control, Fu variants mark a flag update
	typedef enum logic [2:0] {
		nextOp,
		nextInc,
		nextEof,
		nextIncEof,
		nextEofFu,
		nextIncEofFu
	} nextCtlT;

	typedef enum logic [3:0] {
		uopNop, uopSma, uopSmw, uopSrm, uopInc16, uopDec16, uopSx16r,
		uopAddx16, uopSubx16, uopSpc, uopBit, uopShl, uopCeti
	} uopOpT;

	typedef enum logic [3:0] {
		regNull, regA, regB, regC, regD, regE, regH, regL,
		regHl, regPc, regSp, regX8, regX16
	} uopRegT;

	// One ROM word, 11 bits
	typedef struct packed {
		nextCtlT nextCtl;
		uopOpT operation;
		uopRegT operand;
	} uopT;

	// Queue payload, flow index plus the byte that selected it
	typedef struct packed {
		logic [flowIdxWidth-1:0] flowIdx;
		logic [opcodeWidth-1:0] opcode;
	} flowEntryT;

endpackage

`default_nettype wire

//--- design/ucodeSequencer.sv
`timescale 1ns/10ps
`default_nettype none

// Walks the micro-op ROM one word per cycle
module ucodeSequencer (
	input logic clock,
	input logic rstN,
	input logic notEmpty,
	input ucodePkg::flowEntryT head,
	output logic pop,
	output logic uopValid,
	output ucodePkg::uopT uop,
	output logic flowDone,
	output logic [ucodePkg::pcWidth-1:0] pc
);

	`include "ucodeFlows.svh"

	// Flow in progress
	logic busy;
	// Micro-program counter
	logic [ucodePkg::flowIdxWidth-1:0] upc;
	ucodePkg::uopT romWord;
	logic isEof;
	logic isInc;

	assign romWord = romRead(upc);

	//////////////////////////////////////////////////////////////////////
	// Next control decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		isEof = romWord.nextCtl inside {ucodePkg::nextEof, ucodePkg::nextIncEof,
			ucodePkg::nextEofFu, ucodePkg::nextIncEofFu};
		isInc = romWord.nextCtl inside {ucodePkg::nextInc, ucodePkg::nextIncEof,
			ucodePkg::nextIncEofFu};
	end

	assign uopValid = busy;
	assign uop = romWord;
	assign flowDone = busy && isEof;
	// Take next entry when idle or on the last word so flows run without a gap
	assign pop = notEmpty && (!busy || isEof);

	//////////////////////////////////////////////////////////////////////
	// Sequencing and pc
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			upc <= '0;
			pc <= '0;
		end
		else
		begin
			if (pop)
			begin
				busy <= 1'b1;
				upc <= head.flowIdx;
			end
			else if (flowDone)
				busy <= 1'b0;
			else if (busy)
				upc <= upc + 1'b1;

			// Only inc words move pc as jumps are not executed here
			if (busy && isInc)
				pc <= pc + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Every decoded flow terminates inside the populated ROM
	upcInRom: assert property (@(posedge clock) disable iff (!rstN)
		busy |-> upc <= ucodePkg::romLastAddr);

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/ucodePkg.sv
design/prefixDecoder.sv
design/flowQueue.sv
design/ucodeSequencer.sv
design/ucodeCore.sv
verif/ucodeCoreTb.sv

//--- verif/ucodeCoreTb.sv
`timescale 1ns/10ps
`default_nettype none

module ucodeCoreTb;

	localparam int instrCount = 300;
	// Instructions sent with only the minimum gap, to fill the queue
	localparam int burstLength = 40;
	localparam int fullTimeout = 100;
	localparam int drainTimeout = 400;

	// Expected result of one instruction, in strobe order
	typedef struct packed {
		logic isCb;
		logic [ucodePkg::opcodeWidth-1:0] code;
		logic [2:0] byteLen;
		logic [2:0] flowLen;
	} expectT;

	logic clock;
	logic rstN;
	logic opStrobe;
	logic [ucodePkg::opcodeWidth-1:0] opByte;
	logic full;
	logic uopValid;
	ucodePkg::uopT uop;
	logic flowDone;
	logic [ucodePkg::pcWidth-1:0] pc;

	expectT modelQ [$];
	logic [15:0] lfsrState;
	logic [ucodePkg::pcWidth-1:0] expPc;
	logic pcCheckPending;
	logic sawFull;
	logic lastWasDone;
	int uopCount;
	int errorCount;
	int timeoutCount;
	int flowCount;
	int issuedCount;
	int backToBack;

	ucodeCore i_ucodeCore (
		.clock(clock),
		.rstN(rstN),
		.opStrobe(opStrobe),
		.opByte(opByte),
		.full(full),
		.uopValid(uopValid),
		.uop(uop),
		.flowDone(flowDone),
		.pc(pc)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Random source and reference tables
	//////////////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [7:0] randomBits(input int n);
		logic [7:0] value;
		int i;
		value = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Supported opcodes and the prefix itself
	function automatic logic isReservedMain(input logic [7:0] code);
		return code inside {ucodePkg::opNop, ucodePkg::opIncB, ucodePkg::opDecB,
			ucodePkg::opLdBn, ucodePkg::opLdCn, ucodePkg::opJrn, ucodePkg::opLdHLnn,
			ucodePkg::opIncHL, ucodePkg::opDi, ucodePkg::opCpn, ucodePkg::opPrefixCb};
	endfunction

	// Micro-ops per flow
	function automatic int flowLenOf(input logic isCb, input logic [7:0] code);
		int len;
		if (isCb)
			len = (code == ucodePkg::cbBit7H || code == ucodePkg::cbRlC) ? 4 : 1;
		else if (code == ucodePkg::opLdBn || code == ucodePkg::opLdCn)
			len = 3;
		else if (code == ucodePkg::opJrn)
			len = 6;
		else if (code == ucodePkg::opLdHLnn || code == ucodePkg::opCpn)
			len = 4;
		else
			len = 1;
		return len;
	endfunction

	// Instruction bytes, so pc steps per flow
	// Unknown CB code runs the default flow, which steps pc once
	function automatic int byteLenOf(input logic isCb, input logic [7:0] code);
		int len;
		if (isCb)
			len = (code == ucodePkg::cbBit7H || code == ucodePkg::cbRlC) ? 2 : 1;
		else if (code inside {ucodePkg::opLdBn, ucodePkg::opLdCn, ucodePkg::opJrn,
			ucodePkg::opCpn})
			len = 2;
		else if (code == ucodePkg::opLdHLnn)
			len = 3;
		else
			len = 1;
		return len;
	endfunction

	function automatic logic isEofCode(input ucodePkg::nextCtlT ctl);
		return ctl inside {ucodePkg::nextEof, ucodePkg::nextIncEof,
			ucodePkg::nextEofFu, ucodePkg::nextIncEofFu};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input int actual, input int expected, input string what);
		if (actual != expected)
		begin
			errorCount++;
			$display("error at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected);
		end
	endtask

	// Supported list plus unknown main and CB codes
	task automatic pickInstruction(output logic isCb, output logic [7:0] code);
		logic [3:0] sel;
		int tries;
		sel = 4'(randomBits(4));
		isCb = 1'b0;
		case (sel)
			4'd1: code = ucodePkg::opIncB;
			4'd2: code = ucodePkg::opDecB;
			4'd3: code = ucodePkg::opLdBn;
			4'd4: code = ucodePkg::opLdCn;
			4'd5: code = ucodePkg::opJrn;
			4'd6: code = ucodePkg::opLdHLnn;
			4'd7: code = ucodePkg::opIncHL;
			4'd8: code = ucodePkg::opDi;
			4'd9: code = ucodePkg::opCpn;
			4'd10:
			begin
				isCb = 1'b1;
				code = ucodePkg::cbBit7H;
			end
			4'd11:
			begin
				isCb = 1'b1;
				code = ucodePkg::cbRlC;
			end
			4'd12, 4'd15:
			begin
				code = randomBits(8);
				for (tries = 0; tries < 8 && isReservedMain(code); tries++)
					code = randomBits(8);
				if (isReservedMain(code))
					code = 8'hD3;
			end
			4'd13:
			begin
				isCb = 1'b1;
				code = randomBits(8);
				// Inverted known codes are unknown CB codes
				if (code == ucodePkg::cbBit7H || code == ucodePkg::cbRlC)
					code = ~code;
			end
			default: code = ucodePkg::opNop;
		endcase
	endtask

	// Strobe one byte once full is low, then one idle cycle at least
	task automatic sendByte(input logic [7:0] b);
		int waitCycles;
		waitCycles = 0;
		@(posedge clock);
		while (full && waitCycles < fullTimeout)
		begin
			@(posedge clock);
			waitCycles++;
		end
		if (full)
		begin
			$display("Timed out at %0t ns waiting for full to fall", $time);
			timeoutCount++;
		end
		else
		begin
			opStrobe <= 1'b1;
			opByte <= b;
			@(posedge clock);
			opStrobe <= 1'b0;
		end
	endtask

	initial
	begin
		logic isCb;
		logic [7:0] code;
		expectT e;
		int gap;
		int n;
		int waitCycles;
		lfsrState = 16'd18;
		expPc = '0;
		pcCheckPending = 1'b0;
		sawFull = 1'b0;
		lastWasDone = 1'b0;
		uopCount = 0;
		errorCount = 0;
		timeoutCount = 0;
		flowCount = 0;
		issuedCount = 0;
		backToBack = 0;
		rstN <= 1'b0;
		opStrobe <= 1'b0;
		opByte <= '0;

		// Outputs while reset is held
		repeat (2) @(posedge clock);
		checkValue(int'(uopValid), 0, "uopValid in reset");
		checkValue(int'(flowDone), 0, "flowDone in reset");
		checkValue(int'(full), 0, "full in reset");
		checkValue(int'(pc), 0, "pc in reset");
		rstN <= 1'b1;

		for (n = 0; n < instrCount && timeoutCount == 0; n++)
		begin
			pickInstruction(isCb, code);
			e.isCb = isCb;
			e.code = code;
			e.byteLen = 3'(byteLenOf(isCb, code));
			e.flowLen = 3'(flowLenOf(isCb, code));
			if (isCb)
				sendByte(ucodePkg::opPrefixCb);
			if (timeoutCount == 0)
				sendByte(code);
			if (timeoutCount == 0)
			begin
				modelQ.push_back(e);
				issuedCount++;
			end
			// Random idle stretches after the initial burst
			if (n >= burstLength && randomBits(2) == 8'd3)
				gap = int'(randomBits(3));
			else
				gap = 0;
			repeat (gap) @(posedge clock);
		end

		// Drain the model queue
		waitCycles = 0;
		while ((modelQ.size() != 0 || pcCheckPending) && waitCycles < drainTimeout)
		begin
			@(posedge clock);
			waitCycles++;
		end
		if (modelQ.size() != 0 || pcCheckPending)
		begin
			$display("Timed out waiting for %0d flows to complete", modelQ.size());
			timeoutCount++;
		end

		checkValue(flowCount, issuedCount, "completed flows");
		checkValue(int'(sawFull), 1, "full never rose");
		checkValue(int'(backToBack != 0), 1, "no back-to-back flows seen");
		checkValue(int'(uopValid), 0, "uopValid after drain");

		$display("Errors: %0d, timeouts: %0d, flows checked: %0d",
			errorCount, timeoutCount, flowCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Monitor, mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock)
	begin : monitor
		expectT done;
		if (rstN)
		begin
			if (full)
				sawFull = 1'b1;
			// pc holds every inc of the flow that ended last cycle
			if (pcCheckPending)
			begin
				checkValue(int'(pc), int'(expPc), "pc after flow");
				pcCheckPending = 1'b0;
			end
			if (uopValid)
			begin
				uopCount++;
				if (lastWasDone)
					backToBack++;
				checkValue(int'(isEofCode(uop.nextCtl)), int'(flowDone),
					"end-of-flow code and flowDone disagree");
				if (flowDone)
				begin
					checkValue(int'(modelQ.size() != 0), 1, "flowDone with nothing pending");
					if (modelQ.size() != 0)
					begin
						done = modelQ.pop_front();
						checkValue(uopCount, int'(done.flowLen),
							$sformatf("micro-ops for code %02h, cb %0d", done.code, done.isCb));
						expPc = expPc + (ucodePkg::pcWidth)'(done.byteLen);
						pcCheckPending = 1'b1;
						flowCount++;
					end
					uopCount = 0;
				end
			end
			else
			begin
				checkValue(uopCount, 0, "idle cycle inside a flow");
				checkValue(int'(flowDone), 0, "flowDone without uopValid");
				uopCount = 0;
			end
			lastWasDone = uopValid && flowDone;
		end
	end

endmodule

`default_nettype wire
